/* Bender.yml */
package:
  name: local_bus_sizing

sources:
  - include_dirs:
      - source
    files:
      - source/cpuBusPkg.sv
      - source/amigaBusPkg.sv
      - source/localBusIf.sv
      - source/transferDescriptor.sv
      - source/busSizer.sv
      - source/laneSteer.sv
      - source/bufferControl.sv
      - source/localBusSizing.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/amigaPortModel.sv
      - tb/tbLocalBusSizing.sv

/* source/amigaBusPkg.sv */
// Local bus types for the sizing bridge, imported by the RTL blocks
`default_nettype none

package amigaBusPkg;

    // Width of the addressed local bus port
    typedef enum logic {
        PORT_32 = 1'b0,
        PORT_16 = 1'b1
    } portSize_e;

    // Sequencer phase
    typedef enum logic [1:0] {
        PH_IDLE   = 2'b00,
        PH_FIRST  = 2'b01,
        PH_SECOND = 2'b10,
        PH_ACK    = 2'b11
    } cycPhase_e;

    // One transfer as latched at the start pulse
    typedef struct packed {
        logic [1:0]        addr;
        cpuBusPkg::size_e  size;
        logic              rnw;
        portSize_e         portSize;
        // Long or line on a 16-bit port
        logic              twoCycle;
        logic              isLine;
    } transferDesc_t;

endpackage

`default_nettype wire

/* source/bufferControl.sv */
// Data buffer enable and direction, bus grant pass-through and DMA indication
`timescale 1ns/1ps
`default_nettype none

module bufferControl (
    input  logic       clk80,
    input  logic       rst,
    input  logic       bg,
    input  logic       lbEn,
    output logic       bufEn,
    output logic       bufDir,
    output logic       cpuBg,
    output logic       dma,
    localBusIf.buffer  bus
);

    //////////////////////////////
    // Registered buffer control
    //////////////////////////////

    always_ff @(posedge clk80) begin
        if (rst) begin
            bufEn  <= 1'b0;
            bufDir <= 1'b0;
            cpuBg  <= 1'b0;
            // Assume another master until bg is seen
            dma    <= 1'b1;
        end else begin
            // Open only while the processor owns the bus
            bufEn  <= bus.active && lbEn && bg;
            // High for reads, towards the processor
            bufDir <= bus.desc.rnw;
            cpuBg  <= bg;
            dma    <= !bg;
        end
    end

    // Direction never flips under an open buffer
    dirStable: assert property (
        @(posedge clk80) disable iff (rst)
        bufEn ##1 bufEn |-> $stable(bufDir)
    ) else $error("bufDir changed while bufEn high");

endmodule

`default_nettype wire

/* source/busSizer.sv */
// Cycle sequencer instantiated by the top level to run one or two local bus transfers per transfer
`timescale 1ns/1ps
`default_nettype none

module busSizer (
    input  logic        clk80,
    input  logic        rst,
    input  logic        tsCpu,
    input  logic        tack,
    input  logic        tea,
    input  logic        tci,
    output logic        tsAmiga,
    output logic        taCpu,
    output logic        teaCpu,
    output logic        tbiCpu,
    output logic        tciCpu,
    output logic [1:0]  addrAmiga,
    localBusIf.sequencer bus
);

    import amigaBusPkg::*;

    cycPhase_e phase;
    logic      active;
    logic      secondHalf;
    logic      tciSeen;
    logic      lastHalf;
    logic      termAmiga;

    // Nothing more to issue after this acknowledge
    assign lastHalf  = secondHalf || !bus.desc.twoCycle;
    // Local bus ends the current sub-transfer
    assign termAmiga = tack || tea;

    assign bus.phase      = phase;
    assign bus.active     = active;
    assign bus.secondHalf = secondHalf;
    // Read data only counts on a clean acknowledge
    assign bus.capture    = active && tack && !tea;

    // Second half always lands on A1 set
    assign addrAmiga = secondHalf ? {1'b1, bus.desc.addr[0]} : bus.desc.addr;

    //////////////////////////////
    // Phase machine
    //////////////////////////////

    always_ff @(posedge clk80) begin
        if (rst) begin
            phase      <= PH_IDLE;
            active     <= 1'b0;
            secondHalf <= 1'b0;
            tciSeen    <= 1'b0;
            tsAmiga    <= 1'b0;
            taCpu      <= 1'b0;
            teaCpu     <= 1'b0;
            tbiCpu     <= 1'b0;
            tciCpu     <= 1'b0;
        end else begin
            // Pulses last one cycle
            tsAmiga <= 1'b0;
            taCpu   <= 1'b0;
            teaCpu  <= 1'b0;
            tbiCpu  <= 1'b0;
            tciCpu  <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (tsCpu) begin
                        phase      <= PH_FIRST;
                        active     <= 1'b1;
                        secondHalf <= 1'b0;
                        tciSeen    <= 1'b0;
                        tsAmiga    <= 1'b1;
                    end
                end
                PH_FIRST, PH_SECOND: begin
                    if (termAmiga) begin
                        if (tea) begin
                            // Abort without a second half
                            phase  <= PH_ACK;
                            active <= 1'b0;
                            teaCpu <= 1'b1;
                        end else if (!lastHalf) begin
                            phase      <= PH_SECOND;
                            secondHalf <= 1'b1;
                            tciSeen    <= tci;
                            tsAmiga    <= 1'b1;
                        end else begin
                            phase  <= PH_ACK;
                            active <= 1'b0;
                            taCpu  <= 1'b1;
                            tbiCpu <= bus.desc.isLine;
                            tciCpu <= tciSeen || tci;
                        end
                    end
                end
                default: begin
                    // Acknowledge cycle returns to idle
                    phase      <= PH_IDLE;
                    secondHalf <= 1'b0;
                end
            endcase
        end
    end

    //////////////////////////////
    // Protocol checks
    //////////////////////////////

    // Local bus answers only an issued start
    noAckWhenIdle: assert property (
        @(posedge clk80) disable iff (rst)
        termAmiga |-> phase != PH_IDLE
    ) else $error("tack or tea outside a transfer");

    // Ignored start while busy
    noOverlap: assert property (
        @(posedge clk80) disable iff (rst)
        tsCpu |-> phase == PH_IDLE
    ) else $error("tsCpu while a transfer is in flight");

endmodule

`default_nettype wire

/* source/busSizing_macros.svh */
// Bus width macros for the sizing bridge, included by RTL and testbench files
`ifndef BUS_SIZING_MACROS_SVH
`define BUS_SIZING_MACROS_SVH

//////////////////////////////
// Data path widths
//////////////////////////////

// Full processor and local bus word
`define DATA_W 32

// One half-word, the width of a 16-bit port
`define HALF_W 16

// Byte lanes across the full word
`define LANES 4

// A 16-bit port sits on the two
// upper lanes of the local bus,
// so HALF_W covers lanes 3 and 2

`endif

/* source/cpuBusPkg.sv */
// Processor side types for the sizing bridge, imported by the RTL blocks
`default_nettype none

`include "busSizing_macros.svh"

package cpuBusPkg;

    //////////////////////////////
    // Transfer size code
    //////////////////////////////

    // Encoding as on the 68040 SIZ pins
    typedef enum logic [1:0] {
        SIZ_LONG = 2'b00,
        SIZ_BYTE = 2'b01,
        SIZ_WORD = 2'b10,
        SIZ_LINE = 2'b11
    } size_e;

    //////////////////////////////
    // Data word
    //////////////////////////////

    // Upper and lower half-word view
    typedef struct packed {
        logic [`HALF_W-1:0] upper;
        logic [`HALF_W-1:0] lower;
    } halfWords_t;

    // Same 32 bits seen as one long
    // or as two half-words
    typedef union packed {
        logic [`DATA_W-1:0] lword;
        halfWords_t         half;
    } busWord_u;

endpackage

`default_nettype wire

/* source/laneSteer.sv */
// Byte lane routing for writes and half-word assembly of read data
`timescale 1ns/1ps
`default_nettype none

module laneSteer (
    input  logic                clk80,
    input  logic                rst,
    input  cpuBusPkg::busWord_u cpuDataIn,
    input  cpuBusPkg::busWord_u amigaDataIn,
    output cpuBusPkg::busWord_u cpuDataOut,
    output cpuBusPkg::busWord_u amigaDataOut,
    output logic                amigaDataOe,
    output logic                cpuDataOe,
    localBusIf.steer            bus
);

    import cpuBusPkg::*;
    import amigaBusPkg::*;

    busWord_u wrHold;
    busWord_u rdHold;
    logic     useLower;
    logic     halfPort;
    logic     lastHalf;

    assign halfPort = (bus.desc.portSize == PORT_16);
    // Lower processor half travels on the upper lanes
    assign useLower = bus.secondHalf || bus.desc.addr[1];
    assign lastHalf = bus.secondHalf || !bus.desc.twoCycle;

    // Write data held from the start pulse on
    always_ff @(posedge clk80) begin
        if (bus.phase == PH_IDLE) begin
            wrHold <= cpuDataIn;
        end
        // Read assembly
        if (bus.capture) begin
            if (!halfPort) begin
                rdHold <= amigaDataIn;
            end else if (useLower) begin
                rdHold.half.lower <= amigaDataIn.half.upper;
            end else begin
                rdHold.half.upper <= amigaDataIn.half.upper;
            end
        end
    end

    // 16-bit port sees only lanes 3 and 2
    always_comb begin
        amigaDataOut = wrHold;
        if (halfPort && useLower) begin
            amigaDataOut.half.upper = wrHold.half.lower;
        end
    end

    // Drive the local bus for the whole write
    assign amigaDataOe = bus.active && !bus.desc.rnw;

    assign cpuDataOut = rdHold;

    // Read data goes out in the taCpu cycle
    always_ff @(posedge clk80) begin
        if (rst) begin
            cpuDataOe <= 1'b0;
        end else begin
            cpuDataOe <= bus.capture && bus.desc.rnw && lastHalf;
        end
    end

endmodule

`default_nettype wire

/* source/localBusIf.sv */
// Cycle state shared by the sequencer, lane steering and buffer control
`timescale 1ns/1ps
`default_nettype none

interface localBusIf;

    import amigaBusPkg::*;

    // Latched transfer, driven by the descriptor block
    transferDesc_t desc;

    // Sequencer phase
    cycPhase_e phase;

    // High from the Amiga start to the acknowledge
    logic active;

    // One cycle, data valid on the local bus
    logic capture;

    // Second sub-transfer of a split long
    logic secondHalf;

    modport sequencer (
        input  desc,
        output phase,
        output active,
        output capture,
        output secondHalf
    );

    modport steer (
        input desc,
        input phase,
        input active,
        input capture,
        input secondHalf
    );

    // Buffer control only needs ownership and direction
    modport buffer (
        input active,
        input desc
    );

endinterface

`default_nettype wire

/* source/localBusSizing.sv */
// Top level of the bus sizing bridge, plain ports to processor and local bus
`timescale 1ns/1ps
`default_nettype none

`include "busSizing_macros.svh"

module localBusSizing (
    input  logic              clk80,
    input  logic              rst,
    input  logic              tsCpu,
    input  logic              rnw,
    input  logic              portSize,
    input  logic              lbEn,
    input  logic              bg,
    input  logic              tack,
    input  logic              tea,
    input  logic              tci,
    input  logic [1:0]        addrCpu,
    input  logic [1:0]        sizCpu,
    input  logic [`DATA_W-1:0] cpuDataIn,
    input  logic [`DATA_W-1:0] amigaDataIn,
    output logic [1:0]        addrAmiga,
    output logic              tsAmiga,
    output logic              taCpu,
    output logic              teaCpu,
    output logic              tbiCpu,
    output logic              tciCpu,
    output logic              bufEn,
    output logic              bufDir,
    output logic              cpuBg,
    output logic              dma,
    output logic              amigaDataOe,
    output logic              cpuDataOe,
    output logic [`DATA_W-1:0] cpuDataOut,
    output logic [`DATA_W-1:0] amigaDataOut
);

    localBusIf busIf ();

    transferDescriptor descUnit (.clk80(clk80), .rst(rst), .tsCpu(tsCpu), .rnw(rnw),
        .portSize(portSize), .addrCpu(addrCpu), .sizCpu(cpuBusPkg::size_e'(sizCpu)),
        .desc(busIf.desc));

    // Phase machine and processor handshake
    busSizer sizerUnit (.clk80(clk80), .rst(rst), .tsCpu(tsCpu), .tack(tack), .tea(tea),
        .tci(tci), .tsAmiga(tsAmiga), .taCpu(taCpu), .teaCpu(teaCpu), .tbiCpu(tbiCpu),
        .tciCpu(tciCpu), .addrAmiga(addrAmiga), .bus(busIf.sequencer));

    laneSteer steerUnit (.clk80(clk80), .rst(rst), .cpuDataIn(cpuDataIn),
        .amigaDataIn(amigaDataIn), .cpuDataOut(cpuDataOut), .amigaDataOut(amigaDataOut),
        .amigaDataOe(amigaDataOe), .cpuDataOe(cpuDataOe), .bus(busIf.steer));

    bufferControl bufferUnit (.clk80(clk80), .rst(rst), .bg(bg), .lbEn(lbEn),
        .bufEn(bufEn), .bufDir(bufDir), .cpuBg(cpuBg), .dma(dma), .bus(busIf.buffer));

endmodule

`default_nettype wire

/* source/transferDescriptor.sv */
// Latches one processor transfer at its start pulse and plans the local bus split
`timescale 1ns/1ps
`default_nettype none

module transferDescriptor (
    input  logic                      clk80,
    input  logic                      rst,
    input  logic                      tsCpu,
    input  logic                      rnw,
    input  logic                      portSize,
    input  logic [1:0]                addrCpu,
    input  cpuBusPkg::size_e          sizCpu,
    output amigaBusPkg::transferDesc_t desc
);

    import cpuBusPkg::*;
    import amigaBusPkg::*;

    logic wideSize;
    logic halfPort;

    // Long and line both need 32 bits
    assign wideSize = (sizCpu == SIZ_LONG) || (sizCpu == SIZ_LINE);
    assign halfPort = (portSize_e'(portSize) == PORT_16);

    always_ff @(posedge clk80) begin
        if (rst) begin
            desc <= '0;
        end else if (tsCpu) begin
            // Line becomes one long, aligned
            desc.addr     <= (sizCpu == SIZ_LINE) ? 2'b00 : addrCpu;
            desc.size     <= sizCpu;
            desc.rnw      <= rnw;
            desc.portSize <= portSize_e'(portSize);
            desc.twoCycle <= wideSize && halfPort;
            desc.isLine   <= (sizCpu == SIZ_LINE);
        end
    end

    // Processor never issues a misaligned word
    wordAligned: assert property (
        @(posedge clk80) disable iff (rst)
        (tsCpu && sizCpu == SIZ_WORD) |-> !addrCpu[0]
    ) else $error("word transfer at odd address");

endmodule

`default_nettype wire

/* sources.f */
+incdir+source
source/cpuBusPkg.sv
source/amigaBusPkg.sv
source/localBusIf.sv
source/transferDescriptor.sv
source/busSizer.sv
source/laneSteer.sv
source/bufferControl.sv
source/localBusSizing.sv
tb/amigaPortModel.sv
tb/tbLocalBusSizing.sv

/* tb/amigaPortModel.sv */
// Local bus responder for the testbench, answers each tsAmiga from a small memory
`timescale 1ns/1ps
`default_nettype none

`include "busSizing_macros.svh"

module amigaPortModel (
    input  logic               clk80,
    input  logic               rst,
    input  logic               portSize,
    input  logic [3:0]         respDelay,
    input  logic               armTea,
    input  logic               tciOn,
    input  logic [3:0]         wordIdx,
    input  logic               tsAmiga,
    input  logic [1:0]         addrAmiga,
    input  logic [`DATA_W-1:0] amigaDataOut,
    input  logic               amigaDataOe,
    output logic               tack,
    output logic               tea,
    output logic               tci,
    output logic [`DATA_W-1:0] amigaDataIn
);

    // Backing store, one long per index
    logic [`DATA_W-1:0] mem [0:15];

    // Transfer log read by the test tasks
    logic [1:0]         logAddr [0:63];
    logic [`DATA_W-1:0] logData [0:63];
    logic               logWrite [0:63];
    int                 logCount;

    //////////////////////////////
    // Responder
    //////////////////////////////

    initial begin : responder
        logic [1:0]         addr;
        logic               isWrite;
        logic [`DATA_W-1:0] wdata;
        logic [`HALF_W-1:0] half;
        // Fill depends on every index bit
        for (int i = 0; i < 16; i++) begin
            mem[i] = 32'h9e3779b9 * (i + 1);
        end
        logCount    = 0;
        tack        = 1'b0;
        tea         = 1'b0;
        tci         = 1'b0;
        amigaDataIn = '0;
        forever begin
            @(negedge clk80);
            // Terminations are one-cycle pulses
            tack = 1'b0;
            tea  = 1'b0;
            tci  = 1'b0;
            if (!rst && tsAmiga) begin
                addr    = addrAmiga;
                isWrite = amigaDataOe;
                wdata   = amigaDataOut;
                logAddr[logCount % 64]  = addr;
                logData[logCount % 64]  = wdata;
                logWrite[logCount % 64] = isWrite;
                logCount++;
                repeat (respDelay) @(negedge clk80);
                if (armTea) begin
                    tea = 1'b1;
                end else begin
                    tack = 1'b1;
                    tci  = tciOn;
                    if (isWrite && portSize) begin
                        // 16-bit port listens on lanes 3 and 2 only
                        if (addr[1]) begin
                            mem[wordIdx][`HALF_W-1:0] = wdata[`DATA_W-1:`HALF_W];
                        end else begin
                            mem[wordIdx][`DATA_W-1:`HALF_W] = wdata[`DATA_W-1:`HALF_W];
                        end
                    end else if (isWrite) begin
                        mem[wordIdx] = wdata;
                    end else if (portSize) begin
                        half = addr[1] ? mem[wordIdx][`HALF_W-1:0]
                                       : mem[wordIdx][`DATA_W-1:`HALF_W];
                        // Lower lanes carry junk
                        amigaDataIn = {half, ~half};
                    end else begin
                        amigaDataIn = mem[wordIdx];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tbLocalBusSizing.sv */
// Directed testbench run as the simulation top to exercise the sizing bridge
`timescale 1ns/1ps
`default_nettype none

`include "busSizing_macros.svh"

module tbLocalBusSizing;

    import cpuBusPkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int MAX_DELAY = 5;
    localparam int NUM_TESTS = 6;
    localparam int XFERS_PER_TEST = 4;
    // Two halves of up to the longest delay plus overhead each
    localparam int XFER_CYCLES = 2 * (MAX_DELAY + 10);
    localparam int WATCHDOG_NS = 2 * NUM_TESTS * XFERS_PER_TEST * XFER_CYCLES * CLK_PERIOD;

    logic               clk80;
    logic               rst;
    logic               tsCpu;
    logic               rnw;
    logic               portSize;
    logic               lbEn;
    logic               bg;
    logic               tack;
    logic               tea;
    logic               tci;
    logic [1:0]         addrCpu;
    logic [1:0]         sizCpu;
    logic [`DATA_W-1:0] cpuDataIn;
    logic [`DATA_W-1:0] amigaDataIn;
    logic [1:0]         addrAmiga;
    logic               tsAmiga;
    logic               taCpu;
    logic               teaCpu;
    logic               tbiCpu;
    logic               tciCpu;
    logic               bufEn;
    logic               bufDir;
    logic               cpuBg;
    logic               dma;
    logic               amigaDataOe;
    logic               cpuDataOe;
    logic [`DATA_W-1:0] cpuDataOut;
    logic [`DATA_W-1:0] amigaDataOut;

    // Responder controls
    logic [3:0] respDelay;
    logic       armTea;
    logic       tciOn;
    logic [3:0] wordIdx;

    integer seed;
    int     errCount;
    int     testsRun;
    int     testErrBase;
    int     logBase;

    // Results of the last transfer
    int                 resStarts;
    logic               resTa;
    logic               resTea;
    logic               resTbi;
    logic               resTci;
    logic               resOe;
    logic               resBufEn;
    logic               resDirBad;
    logic [`DATA_W-1:0] resData;

    localBusSizing UUT (.*);

    amigaPortModel amigaPort (.*);

    initial begin
        clk80 = 1'b0;
        forever #(CLK_PERIOD / 2) clk80 = ~clk80;
    end

    //////////////////////////////
    // Reporting
    //////////////////////////////

    task automatic reportMismatch(input string sigName, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("FAILED %s: got %h, expected %h", sigName, got, exp);
        errCount++;
    endtask

    task automatic reportProblem(input string msg);
        $display("%s", msg);
        errCount++;
    endtask

    task automatic openTest();
        testErrBase = errCount;
        testsRun++;
    endtask

    task automatic closeTest(input string name);
        if (errCount == testErrBase) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errCount - testErrBase);
        end
    endtask

    // Position of the k-th local bus transfer of the last processor transfer
    function automatic int logSlot(input int k);
        return (logBase + k) % 64;
    endfunction

    //////////////////////////////
    // Processor transfer
    //////////////////////////////

    task automatic doTransfer(input logic [3:0] idx, input logic [1:0] addr,
                              input logic [1:0] siz, input logic rd,
                              input logic [31:0] wdata);
        int waitCycles;
        @(negedge clk80);
        logBase   = amigaPort.logCount;
        wordIdx   = idx;
        tsCpu     = 1'b1;
        addrCpu   = addr;
        sizCpu    = siz;
        rnw       = rd;
        cpuDataIn = wdata;
        resStarts = 0;
        resBufEn  = 1'b0;
        resDirBad = 1'b0;
        @(negedge clk80);
        tsCpu      = 1'b0;
        waitCycles = 0;
        while (!taCpu && !teaCpu && waitCycles < XFER_CYCLES) begin
            if (tsAmiga) resStarts++;
            if (bufEn) resBufEn = 1'b1;
            if (bufEn && bufDir !== rd) resDirBad = 1'b1;
            @(negedge clk80);
            waitCycles++;
        end
        if (waitCycles >= XFER_CYCLES) begin
            reportProblem($sformatf("Transfer never ended: no taCpu or teaCpu in %0d cycles",
                                    XFER_CYCLES));
        end
        resTa   = taCpu;
        resTea  = teaCpu;
        resTbi  = tbiCpu;
        resTci  = tciCpu;
        resOe   = cpuDataOe;
        resData = cpuDataOut;
        // Trailing cycles catch a stray start
        repeat (3) begin
            if (tsAmiga) resStarts++;
            if (bufEn) resBufEn = 1'b1;
            @(negedge clk80);
        end
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic longOn32BitPort();
        logic [31:0] wdata;
        logic [31:0] expWord;
        openTest();
        portSize  = 1'b0;
        respDelay = 4'd2;
        wdata     = $random(seed);
        doTransfer(4'd3, 2'b00, SIZ_LONG, 1'b0, wdata);
        if (resStarts != 1) reportMismatch("tsAmiga count", resStarts, 1);
        if (resTa !== 1'b1) reportMismatch("taCpu", resTa, 1);
        if (amigaPort.logWrite[logSlot(0)] !== 1'b1) begin
            reportMismatch("amigaDataOe", amigaPort.logWrite[logSlot(0)], 1);
        end
        if (amigaPort.logData[logSlot(0)] !== wdata) begin
            reportMismatch("amigaDataOut", amigaPort.logData[logSlot(0)], wdata);
        end
        if (amigaPort.mem[3] !== wdata) reportMismatch("stored word", amigaPort.mem[3], wdata);
        expWord = amigaPort.mem[5];
        doTransfer(4'd5, 2'b00, SIZ_LONG, 1'b1, $random(seed));
        if (resStarts != 1) reportMismatch("tsAmiga count", resStarts, 1);
        if (amigaPort.logWrite[logSlot(0)] !== 1'b0) begin
            reportMismatch("amigaDataOe", amigaPort.logWrite[logSlot(0)], 0);
        end
        if (resOe !== 1'b1) reportMismatch("cpuDataOe", resOe, 1);
        if (resData !== expWord) reportMismatch("cpuDataOut", resData, expWord);
        closeTest("long on 32-bit port");
    endtask

    task automatic longOn16BitPort();
        logic [31:0] wdata;
        logic [31:0] expWord;
        openTest();
        portSize  = 1'b1;
        respDelay = 4'd3;
        wdata     = $random(seed);
        doTransfer(4'd7, 2'b00, SIZ_LONG, 1'b0, wdata);
        if (resStarts != 2) reportMismatch("tsAmiga count", resStarts, 2);
        if (amigaPort.logAddr[logSlot(0)] !== 2'b00) begin
            reportMismatch("addrAmiga first", amigaPort.logAddr[logSlot(0)], 0);
        end
        if (amigaPort.logData[logSlot(0)][31:16] !== wdata[31:16]) begin
            reportMismatch("upper lanes first", amigaPort.logData[logSlot(0)][31:16],
                           wdata[31:16]);
        end
        if (amigaPort.logAddr[logSlot(1)] !== 2'b10) begin
            reportMismatch("addrAmiga second", amigaPort.logAddr[logSlot(1)], 2);
        end
        if (amigaPort.logWrite[logSlot(1)] !== 1'b1) begin
            reportMismatch("amigaDataOe second", amigaPort.logWrite[logSlot(1)], 1);
        end
        if (amigaPort.logData[logSlot(1)][31:16] !== wdata[15:0]) begin
            reportMismatch("upper lanes second", amigaPort.logData[logSlot(1)][31:16],
                           wdata[15:0]);
        end
        if (amigaPort.mem[7] !== wdata) reportMismatch("stored word", amigaPort.mem[7], wdata);
        expWord = amigaPort.mem[9];
        doTransfer(4'd9, 2'b00, SIZ_LONG, 1'b1, $random(seed));
        if (resStarts != 2) reportMismatch("tsAmiga count", resStarts, 2);
        if (resData !== expWord) reportMismatch("cpuDataOut", resData, expWord);
        closeTest("long on 16-bit port");
    endtask

    task automatic wordAtA1On16BitPort();
        logic [31:0] wdata;
        logic [15:0] expHalf;
        openTest();
        portSize  = 1'b1;
        respDelay = 4'd1;
        wdata     = $random(seed);
        doTransfer(4'd2, 2'b10, SIZ_WORD, 1'b0, wdata);
        if (resStarts != 1) reportMismatch("tsAmiga count", resStarts, 1);
        if (amigaPort.logAddr[logSlot(0)] !== 2'b10) begin
            reportMismatch("addrAmiga", amigaPort.logAddr[logSlot(0)], 2);
        end
        if (amigaPort.logData[logSlot(0)][31:16] !== wdata[15:0]) begin
            reportMismatch("upper lanes", amigaPort.logData[logSlot(0)][31:16], wdata[15:0]);
        end
        if (amigaPort.mem[2][15:0] !== wdata[15:0]) begin
            reportMismatch("stored half", amigaPort.mem[2][15:0], wdata[15:0]);
        end
        expHalf = amigaPort.mem[4][15:0];
        doTransfer(4'd4, 2'b10, SIZ_WORD, 1'b1, '0);
        if (resStarts != 1) reportMismatch("tsAmiga count", resStarts, 1);
        if (resData[15:0] !== expHalf) reportMismatch("cpuDataOut lower", resData[15:0], expHalf);
        closeTest("word at A1 on 16-bit port");
    endtask

    task automatic lineRequests();
        logic [31:0] expWord;
        openTest();
        portSize  = 1'b0;
        respDelay = 4'd0;
        tciOn     = 1'b0;
        expWord   = amigaPort.mem[8];
        // Misaligned line still goes out long aligned
        doTransfer(4'd8, 2'b11, SIZ_LINE, 1'b1, '0);
        if (resStarts != 1) reportMismatch("tsAmiga count", resStarts, 1);
        if (amigaPort.logAddr[logSlot(0)] !== 2'b00) begin
            reportMismatch("addrAmiga", amigaPort.logAddr[logSlot(0)], 0);
        end
        if (resTa !== 1'b1) reportMismatch("taCpu", resTa, 1);
        if (resTbi !== 1'b1) reportMismatch("tbiCpu", resTbi, 1);
        if (resTci !== 1'b0) reportMismatch("tciCpu", resTci, 0);
        if (resData !== expWord) reportMismatch("cpuDataOut", resData, expWord);
        portSize  = 1'b1;
        respDelay = MAX_DELAY;
        tciOn     = 1'b1;
        expWord   = amigaPort.mem[10];
        doTransfer(4'd10, 2'b00, SIZ_LINE, 1'b1, '0);
        tciOn = 1'b0;
        if (resStarts != 2) reportMismatch("tsAmiga count", resStarts, 2);
        if (resTbi !== 1'b1) reportMismatch("tbiCpu", resTbi, 1);
        if (resTci !== 1'b1) reportMismatch("tciCpu", resTci, 1);
        if (resData !== expWord) reportMismatch("cpuDataOut", resData, expWord);
        closeTest("line requests");
    endtask

    task automatic teaAbortsSplit();
        openTest();
        portSize  = 1'b1;
        respDelay = 4'd2;
        armTea    = 1'b1;
        doTransfer(4'd11, 2'b00, SIZ_LONG, 1'b0, $random(seed));
        armTea = 1'b0;
        if (resTea !== 1'b1) reportMismatch("teaCpu", resTea, 1);
        if (resTa !== 1'b0) reportMismatch("taCpu", resTa, 0);
        if (resStarts != 1) reportMismatch("tsAmiga count", resStarts, 1);
        closeTest("tea on first half");
    endtask

    task automatic busGrantAndBuffers();
        openTest();
        portSize  = 1'b0;
        respDelay = 4'd2;
        bg        = 1'b0;
        repeat (2) @(negedge clk80);
        // Another master owns the bus
        doTransfer(4'd6, 2'b00, SIZ_LONG, 1'b0, $random(seed));
        if (dma !== 1'b1) reportMismatch("dma", dma, 1);
        if (cpuBg !== 1'b0) reportMismatch("cpuBg", cpuBg, 0);
        if (resBufEn !== 1'b0) reportMismatch("bufEn", resBufEn, 0);
        bg = 1'b1;
        repeat (2) @(negedge clk80);
        doTransfer(4'd6, 2'b00, SIZ_LONG, 1'b1, '0);
        if (dma !== 1'b0) reportMismatch("dma", dma, 0);
        if (cpuBg !== 1'b1) reportMismatch("cpuBg", cpuBg, 1);
        if (resBufEn !== 1'b1) reportMismatch("bufEn", resBufEn, 1);
        if (resDirBad) reportProblem("bufDir did not show a read while bufEn was high");
        doTransfer(4'd6, 2'b00, SIZ_LONG, 1'b0, $random(seed));
        if (resBufEn !== 1'b1) reportMismatch("bufEn", resBufEn, 1);
        if (resDirBad) reportProblem("bufDir did not show a write while bufEn was high");
        closeTest("bus grant and buffers");
    endtask

    //////////////////////////////
    // Sequence and watchdog
    //////////////////////////////

    initial begin
        seed        = 32'h7a4b;
        rst         = 1'b1;
        tsCpu       = 1'b0;
        rnw         = 1'b0;
        portSize    = 1'b0;
        lbEn        = 1'b1;
        bg          = 1'b1;
        addrCpu     = 2'b00;
        sizCpu      = 2'b00;
        cpuDataIn   = '0;
        respDelay   = 4'd0;
        armTea      = 1'b0;
        tciOn       = 1'b0;
        wordIdx     = 4'd0;
        errCount    = 0;
        testsRun    = 0;
        testErrBase = 0;
        logBase     = 0;
        repeat (4) @(negedge clk80);
        rst = 1'b0;
        @(negedge clk80);
        longOn32BitPort();
        longOn16BitPort();
        wordAtA1On16BitPort();
        lineRequests();
        teaAbortsSplit();
        busGrantAndBuffers();
        $display("tests run: %0d, errors: %0d", testsRun, errCount);
        if (errCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire
